/* rtl/rv32i_params.svh */
`ifndef RV32I_PARAMS_SVH
`define RV32I_PARAMS_SVH

// Datapath word
`define RV32I_XLEN 32

// Architectural register index for 32 registers
`define RV32I_RIDX_W 5

`endif

/* rtl/rv32i_pkg.sv */
`include "rv32i_params.svh"

package rv32i_pkg;

    typedef logic [`RV32I_XLEN-1:0]   rv32i_word;
    typedef logic [`RV32I_RIDX_W-1:0] rv32i_reg;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops_t;

    // Same codes as funct3
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic {
        alumux1_rs1_out = 1'b0,
        alumux1_pc_out  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm   = 3'd0,
        alumux2_u_imm   = 3'd1,
        alumux2_b_imm   = 3'd2,
        alumux2_s_imm   = 3'd3,
        alumux2_j_imm   = 3'd4,
        alumux2_rs2_out = 3'd5
    } alumux2_sel_t;

    typedef enum logic {
        cmpmux_rs2_out = 1'b0,
        cmpmux_i_imm   = 1'b1
    } cmpmux_sel_t;

    typedef enum logic [1:0] {
        fw_from_idex  = 2'd0,
        fw_from_exmem = 2'd1,
        fw_from_memwb = 2'd2
    } forward_t;

    typedef enum logic [1:0] {
        wb_alu_out  = 2'd0,
        wb_br_en    = 2'd1, // slt and sltu land here
        wb_pc_plus4 = 2'd2,
        wb_u_imm    = 2'd3
    } wb_sel_t;

    typedef struct packed {
        alu_ops_t       aluop;
        branch_funct3_t cmpop;
        alumux1_sel_t   alumux1_sel;
        alumux2_sel_t   alumux2_sel;
        cmpmux_sel_t    cmpmux_sel;
        wb_sel_t        wb_sel;
        logic           load_regfile;
    } rv32i_ctrl_packet_t;

    typedef struct packed {
        forward_t alumux1_fw;
        forward_t alumux2_fw;
        forward_t cmp_fw;
    } rv32i_fw_t;

    typedef struct packed {
        rv32i_word i_imm;
        rv32i_word u_imm;
        rv32i_word b_imm;
        rv32i_word s_imm;
        rv32i_word j_imm;
        rv32i_reg  rs1;
        rv32i_reg  rs2;
        rv32i_reg  rd;
    } rv32i_inst_t;

    typedef struct packed {
        rv32i_word pc;
        rv32i_word rs1_out;
        rv32i_word rs2_out;
        rv32i_word alu_out; // Filled in by EX
        logic      br_en;
    } rv32i_data_t;

    typedef struct packed {
        logic               valid;
        rv32i_ctrl_packet_t ctrl;
        rv32i_inst_t        inst;
        rv32i_data_t        data;
    } rv32i_packet_t;

    typedef struct packed {
        logic      valid;
        rv32i_reg  rd;
        logic      load_regfile;
        rv32i_word wb_data;
        rv32i_word alu_out;
        logic      br_en;
    } rv32i_wb_t;

endpackage

/* rtl/alu.sv */
module alu (
    input  rv32i_pkg::alu_ops_t  aluop,
    input  rv32i_pkg::rv32i_word a,
    input  rv32i_pkg::rv32i_word b,
    output rv32i_pkg::rv32i_word f
);
    import rv32i_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];  // RV32I shifts use five bits only

    always_comb begin
        unique case (aluop)
            alu_add: f = a + b;
            alu_sub: f = a - b;
            alu_sll: f = a << shamt;
            alu_srl: f = a >> shamt;
            alu_sra: f = rv32i_word'($signed(a) >>> shamt);
            alu_xor: f = a ^ b;
            alu_or:  f = a | b;
            alu_and: f = a & b;
            default: f = '0;
        endcase
    end

endmodule

/* rtl/cmp.sv */
module cmp (
    input  rv32i_pkg::branch_funct3_t cmpop,
    input  rv32i_pkg::rv32i_word      a,
    input  rv32i_pkg::rv32i_word      b,
    output logic                      br_en
);
    import rv32i_pkg::*;

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = (a == b);
    assign lt_s = ($signed(a) < $signed(b));
    assign lt_u = (a < b);

    always_comb begin
        unique case (cmpop)
            beq:     br_en = eq;
            bne:     br_en = !eq;
            blt:     br_en = lt_s;  // Also slt
            bge:     br_en = !lt_s;
            bltu:    br_en = lt_u;  // Also sltu
            bgeu:    br_en = !lt_u;
            default: br_en = 1'b0;
        endcase
    end

endmodule

/* rtl/forward_unit.sv */
module forward_unit (
    input  rv32i_pkg::rv32i_inst_t        idex_inst,
    input  rv32i_pkg::rv32i_ctrl_packet_t idex_ctrl,
    input  rv32i_pkg::rv32i_reg           exmem_rd,
    input  rv32i_pkg::rv32i_reg           memwb_rd,
    input  logic                          exmem_wr,
    input  logic                          memwb_wr,
    output rv32i_pkg::rv32i_fw_t          fw
);
    import rv32i_pkg::*;

    logic rs1_alu_used;
    logic rs2_alu_used;
    logic rs2_cmp_used;

    // Younger stage checked first
    function automatic forward_t pick_source(input rv32i_reg rs, input logic used);
        forward_t src;
        src = fw_from_idex;
        if (used && rs != '0) begin
            if (exmem_wr && exmem_rd == rs) begin
                src = fw_from_exmem;
            end else if (memwb_wr && memwb_rd == rs) begin
                src = fw_from_memwb;
            end
        end
        return src;
    endfunction

    assign rs1_alu_used = (idex_ctrl.alumux1_sel == alumux1_rs1_out);
    assign rs2_alu_used = (idex_ctrl.alumux2_sel == alumux2_rs2_out);
    assign rs2_cmp_used = (idex_ctrl.cmpmux_sel == cmpmux_rs2_out);

    always_comb begin
        fw.alumux1_fw = pick_source(idex_inst.rs1, rs1_alu_used);
        fw.alumux2_fw = pick_source(idex_inst.rs2, rs2_alu_used);
        fw.cmp_fw     = pick_source(idex_inst.rs2, rs2_cmp_used);
    end

endmodule

/* rtl/ex.sv */
module ex (
    input  rv32i_pkg::rv32i_packet_t ex_in,
    input  rv32i_pkg::rv32i_fw_t     fw,
    input  rv32i_pkg::rv32i_word     from_exmem,
    input  rv32i_pkg::rv32i_word     from_memwb,
    output rv32i_pkg::rv32i_packet_t ex_out
);
    import rv32i_pkg::*;

    rv32i_word alumux1_out;
    rv32i_word alumux2_out;
    rv32i_word cmp_a;
    rv32i_word cmpmux_out;
    rv32i_word alu_f;
    logic      br_en;

    alu i_alu (
        .aluop (ex_in.ctrl.aluop),
        .a     (alumux1_out),
        .b     (alumux2_out),
        .f     (alu_f)
    );

    cmp i_cmp (
        .cmpop (ex_in.ctrl.cmpop),
        .a     (cmp_a),
        .b     (cmpmux_out),
        .br_en (br_en)
    );

    // A forwarded value overrides the local select
    always_comb begin
        unique case (fw.alumux1_fw)
            fw_from_idex: begin
                unique case (ex_in.ctrl.alumux1_sel)
                    alumux1_rs1_out: alumux1_out = ex_in.data.rs1_out;
                    alumux1_pc_out:  alumux1_out = ex_in.data.pc;
                    default:         alumux1_out = '0;
                endcase
            end
            fw_from_exmem: alumux1_out = from_exmem;
            fw_from_memwb: alumux1_out = from_memwb;
            default:       alumux1_out = '0;
        endcase
    end

    always_comb begin
        unique case (fw.alumux2_fw)
            fw_from_idex: begin
                unique case (ex_in.ctrl.alumux2_sel)
                    alumux2_i_imm:   alumux2_out = ex_in.inst.i_imm;
                    alumux2_u_imm:   alumux2_out = ex_in.inst.u_imm;
                    alumux2_b_imm:   alumux2_out = ex_in.inst.b_imm;
                    alumux2_s_imm:   alumux2_out = ex_in.inst.s_imm;
                    alumux2_j_imm:   alumux2_out = ex_in.inst.j_imm;
                    alumux2_rs2_out: alumux2_out = ex_in.data.rs2_out;
                    default:         alumux2_out = '0;
                endcase
            end
            fw_from_exmem: alumux2_out = from_exmem;
            fw_from_memwb: alumux2_out = from_memwb;
            default:       alumux2_out = '0;
        endcase
    end

    always_comb begin
        unique case (fw.cmp_fw)
            fw_from_idex: begin
                unique case (ex_in.ctrl.cmpmux_sel)
                    cmpmux_rs2_out: cmpmux_out = ex_in.data.rs2_out;
                    cmpmux_i_imm:   cmpmux_out = ex_in.inst.i_imm;
                    default:        cmpmux_out = '0;
                endcase
            end
            fw_from_exmem: cmpmux_out = from_exmem;
            fw_from_memwb: cmpmux_out = from_memwb;
            default:       cmpmux_out = '0;
        endcase
    end

    // Compare rs1 shares the operand 1 path only when that path carries rs1
    assign cmp_a = (ex_in.ctrl.alumux1_sel == alumux1_rs1_out) ? alumux1_out
                                                                : ex_in.data.rs1_out;

    always_comb begin
        ex_out              = ex_in;
        ex_out.data.alu_out = alu_f;
        ex_out.data.br_en   = br_en;
    end

endmodule

/* rtl/pipe_regs.sv */
module pipe_regs (
    input  logic                     clk,
    input  logic                     arst_n,
    input  rv32i_pkg::rv32i_packet_t id_in,
    input  rv32i_pkg::rv32i_packet_t ex_out,
    output rv32i_pkg::rv32i_packet_t idex,
    output rv32i_pkg::rv32i_reg      exmem_rd,
    output rv32i_pkg::rv32i_reg      memwb_rd,
    output logic                     exmem_wr,
    output logic                     memwb_wr,
    output rv32i_pkg::rv32i_word     from_exmem,
    output rv32i_pkg::rv32i_word     from_memwb,
    output rv32i_pkg::rv32i_wb_t     wb_out
);
    import rv32i_pkg::*;

    logic               idex_vld;
    logic               exmem_vld;
    logic               memwb_vld;
    rv32i_ctrl_packet_t idex_ctrl;
    rv32i_inst_t        idex_inst;
    rv32i_data_t        idex_data;
    rv32i_ctrl_packet_t exmem_ctrl;
    rv32i_inst_t        exmem_inst;
    rv32i_data_t        exmem_data;
    rv32i_word          pc_plus4;
    rv32i_word          exmem_wb_data;
    logic               memwb_load;
    rv32i_word          memwb_data;
    rv32i_word          memwb_alu;
    logic               memwb_br;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idex_vld  <= 1'b0;
            exmem_vld <= 1'b0;
            memwb_vld <= 1'b0;
        end else begin
            idex_vld  <= id_in.valid;
            exmem_vld <= ex_out.valid;
            memwb_vld <= exmem_vld;
        end
    end

    always_ff @(posedge clk) begin
        idex_ctrl  <= id_in.ctrl;
        idex_inst  <= id_in.inst;
        idex_data  <= id_in.data;
        exmem_ctrl <= ex_out.ctrl;
        exmem_inst <= ex_out.inst;
        exmem_data <= ex_out.data;
        memwb_rd   <= exmem_inst.rd;
        memwb_load <= exmem_ctrl.load_regfile;
        memwb_data <= exmem_wb_data;
        memwb_alu  <= exmem_data.alu_out;
        memwb_br   <= exmem_data.br_en;
    end

    assign idex = '{valid: idex_vld, ctrl: idex_ctrl, inst: idex_inst, data: idex_data};

    assign pc_plus4 = exmem_data.pc + rv32i_word'(4);

    // Writeback value picked in MEM so EX/MEM can forward it
    always_comb begin
        unique case (exmem_ctrl.wb_sel)
            wb_alu_out:  exmem_wb_data = exmem_data.alu_out;
            wb_br_en:    exmem_wb_data = rv32i_word'(exmem_data.br_en);
            wb_pc_plus4: exmem_wb_data = pc_plus4;
            wb_u_imm:    exmem_wb_data = exmem_inst.u_imm;
            default:     exmem_wb_data = '0;
        endcase
    end

    assign exmem_rd   = exmem_inst.rd;
    assign exmem_wr   = exmem_vld & exmem_ctrl.load_regfile;
    assign memwb_wr   = memwb_vld & memwb_load;
    assign from_exmem = exmem_wb_data;
    assign from_memwb = memwb_data;

    // Bubbles never show a register write
    assign wb_out = '{valid:        memwb_vld,
                      rd:           memwb_rd,
                      load_regfile: memwb_wr,
                      wb_data:      memwb_data,
                      alu_out:      memwb_alu,
                      br_en:        memwb_br};

endmodule

/* rtl/exec_pipe.sv */
module exec_pipe (
    input  logic                     clk,
    input  logic                     arst_n,
    input  rv32i_pkg::rv32i_packet_t id_in,
    output rv32i_pkg::rv32i_wb_t     wb_out
);
    import rv32i_pkg::*;

    rv32i_packet_t idex;
    rv32i_packet_t ex_out;
    rv32i_fw_t     fw;
    rv32i_reg      exmem_rd;
    rv32i_reg      memwb_rd;
    logic          exmem_wr;
    logic          memwb_wr;
    rv32i_word     from_exmem;
    rv32i_word     from_memwb;

    // ID/EX, EX/MEM and MEM/WB
    pipe_regs i_pipe_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .id_in      (id_in),
        .ex_out     (ex_out),
        .idex       (idex),
        .exmem_rd   (exmem_rd),
        .memwb_rd   (memwb_rd),
        .exmem_wr   (exmem_wr),
        .memwb_wr   (memwb_wr),
        .from_exmem (from_exmem),
        .from_memwb (from_memwb),
        .wb_out     (wb_out)
    );

    forward_unit i_forward_unit (
        .idex_inst (idex.inst),
        .idex_ctrl (idex.ctrl),
        .exmem_rd  (exmem_rd),
        .memwb_rd  (memwb_rd),
        .exmem_wr  (exmem_wr),
        .memwb_wr  (memwb_wr),
        .fw        (fw)
    );

    ex i_ex (
        .ex_in      (idex),
        .fw         (fw),
        .from_exmem (from_exmem),
        .from_memwb (from_memwb),
        .ex_out     (ex_out)
    );

endmodule

/* test/exec_model.sv */
module exec_model (
    input  rv32i_pkg::rv32i_packet_t pkt,
    input  rv32i_pkg::rv32i_word     rs1_val,  // Architectural values
    input  rv32i_pkg::rv32i_word     rs2_val,
    output rv32i_pkg::rv32i_wb_t     wb
);
    timeunit 1ns;
    timeprecision 100ps;

    import rv32i_pkg::*;

    rv32i_word op_a;
    rv32i_word op_b;
    rv32i_word cmp_a;
    rv32i_word cmp_b;
    rv32i_word res;
    rv32i_word data;
    logic      br;
    logic [4:0] sh;

    always_comb begin
        op_a = (pkt.ctrl.alumux1_sel == alumux1_rs1_out) ? rs1_val : pkt.data.pc;
        case (pkt.ctrl.alumux2_sel)
            alumux2_i_imm:   op_b = pkt.inst.i_imm;
            alumux2_u_imm:   op_b = pkt.inst.u_imm;
            alumux2_b_imm:   op_b = pkt.inst.b_imm;
            alumux2_s_imm:   op_b = pkt.inst.s_imm;
            alumux2_j_imm:   op_b = pkt.inst.j_imm;
            alumux2_rs2_out: op_b = rs2_val;
            default:         op_b = '0;
        endcase
        // With pc as operand 1 the compare sees the decode-time rs1
        cmp_a = (pkt.ctrl.alumux1_sel == alumux1_rs1_out) ? rs1_val : pkt.data.rs1_out;
        cmp_b = (pkt.ctrl.cmpmux_sel == cmpmux_rs2_out) ? rs2_val : pkt.inst.i_imm;
        sh = op_b[4:0];
        case (pkt.ctrl.aluop)
            alu_add: res = op_a + op_b;
            alu_sub: res = op_a + ~op_b + 32'd1;
            alu_sll: res = op_a << sh;
            alu_srl: res = op_a >> sh;
            alu_sra: res = (op_a >> sh) | (op_a[31] ? ~(32'hffff_ffff >> sh) : 32'd0);
            alu_xor: res = op_a ^ op_b;
            alu_or:  res = op_a | op_b;
            default: res = op_a & op_b;
        endcase
        case (pkt.ctrl.cmpop)
            beq:     br = (cmp_a == cmp_b);
            bne:     br = (cmp_a != cmp_b);
            blt:     br = ((cmp_a ^ 32'h8000_0000) < (cmp_b ^ 32'h8000_0000));  // Sign flip
            bge:     br = ((cmp_a ^ 32'h8000_0000) >= (cmp_b ^ 32'h8000_0000));
            bltu:    br = (cmp_a < cmp_b);
            bgeu:    br = (cmp_a >= cmp_b);
            default: br = 1'b0;
        endcase
        case (pkt.ctrl.wb_sel)
            wb_alu_out:  data = res;
            wb_br_en:    data = {31'd0, br};
            wb_pc_plus4: data = pkt.data.pc + 32'd4;
            default:     data = pkt.inst.u_imm;
        endcase
        wb = '{valid: pkt.valid, rd: pkt.inst.rd, load_regfile: pkt.valid & pkt.ctrl.load_regfile,
               wb_data: data, alu_out: res, br_en: br};
    end

endmodule

/* test/tb_exec_pipe.sv */
module tb_exec_pipe;
    timeunit 1ns;
    timeprecision 100ps;

    import rv32i_pkg::*;

    logic          clk;
    logic          arst_n;
    rv32i_packet_t id_in;
    rv32i_wb_t     wb_out;
    rv32i_packet_t model_pkt;
    rv32i_word     model_a;
    rv32i_word     model_b;
    rv32i_wb_t     model_wb;
    rv32i_wb_t     exp_wb;
    rv32i_wb_t     exp_q[$];
    rv32i_word     arch[32];   // State after all issued instructions
    rv32i_word     hist1[32];
    rv32i_word     hist2[32];  // What decode sees two issues behind
    integer        seed = 32'h8bbb;
    int            check_errors = 0;
    int            other_errors = 0;
    int            issue_count = 0;
    int            wb_count = 0;
    int            t;

    exec_pipe UUT (.clk(clk), .arst_n(arst_n), .id_in(id_in), .wb_out(wb_out));
    exec_model i_model (.pkt(model_pkt), .rs1_val(model_a), .rs2_val(model_b), .wb(model_wb));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(negedge clk) if (wb_out.valid) wb_count++;

    a_reset: assert property (@(posedge clk) !arst_n |-> !wb_out.valid)
        else begin
            check_errors++;
            $display("Fail wb_out.valid got %h expected 0 in reset", $sampled(wb_out.valid));
        end
    a_valid: assert property (@(posedge clk) wb_out.valid == exp_wb.valid)
        else begin
            check_errors++;
            $display("Fail wb_out.valid got %h expected %h",
                     $sampled(wb_out.valid), $sampled(exp_wb.valid));
        end
    a_load: assert property (@(posedge clk) wb_out.load_regfile == exp_wb.load_regfile)
        else begin
            check_errors++;
            $display("Fail wb_out.load_regfile got %h expected %h",
                     $sampled(wb_out.load_regfile), $sampled(exp_wb.load_regfile));
        end
    a_rd: assert property (@(posedge clk) exp_wb.valid |-> wb_out.rd == exp_wb.rd)
        else begin
            check_errors++;
            $display("Fail wb_out.rd got %h expected %h",
                     $sampled(wb_out.rd), $sampled(exp_wb.rd));
        end
    a_data: assert property (@(posedge clk) exp_wb.valid |-> wb_out.wb_data == exp_wb.wb_data)
        else begin
            check_errors++;
            $display("Fail wb_out.wb_data got %h expected %h",
                     $sampled(wb_out.wb_data), $sampled(exp_wb.wb_data));
        end
    a_alu: assert property (@(posedge clk) exp_wb.valid |-> wb_out.alu_out == exp_wb.alu_out)
        else begin
            check_errors++;
            $display("Fail wb_out.alu_out got %h expected %h",
                     $sampled(wb_out.alu_out), $sampled(exp_wb.alu_out));
        end
    a_br: assert property (@(posedge clk) exp_wb.valid |-> wb_out.br_en == exp_wb.br_en)
        else begin
            check_errors++;
            $display("Fail wb_out.br_en got %h expected %h",
                     $sampled(wb_out.br_en), $sampled(exp_wb.br_en));
        end

    // Register-register op writing rd with the ALU result
    function automatic rv32i_packet_t make_op(alu_ops_t op, rv32i_reg rd, rv32i_reg rs1,
                                              rv32i_reg rs2);
        rv32i_packet_t p;
        p = '0;
        p.valid = 1'b1;
        p.ctrl.aluop = op;
        p.ctrl.cmpop = beq;
        p.ctrl.alumux1_sel = alumux1_rs1_out;
        p.ctrl.alumux2_sel = alumux2_rs2_out;
        p.ctrl.cmpmux_sel = cmpmux_rs2_out;
        p.ctrl.wb_sel = wb_alu_out;
        p.ctrl.load_regfile = 1'b1;
        p.inst = '{i_imm: 32'hffff_fff3, u_imm: 32'h1234_5000, b_imm: 32'h0000_0040,
                   s_imm: 32'h0000_0008, j_imm: 32'h0000_0800, rs1: rs1, rs2: rs2, rd: rd};
        p.data.pc = 32'h0000_1000;
        return p;
    endfunction

    function automatic rv32i_packet_t rand_pkt();
        rv32i_packet_t p;
        logic [31:0]   r;
        r = $random(seed);
        p = make_op(alu_ops_t'(r[2:0]), rv32i_reg'(r[7:5]), rv32i_reg'(r[10:8]),
                    rv32i_reg'(r[13:11]));
        p.valid = (r[16:14] != 3'd0);
        p.ctrl.load_regfile = (r[18:17] != 2'd0);
        p.ctrl.alumux1_sel = alumux1_sel_t'(r[19]);
        p.ctrl.alumux2_sel = (r[20] ? alumux2_rs2_out : alumux2_sel_t'(r[23:21] % 5));
        p.ctrl.cmpmux_sel = cmpmux_sel_t'(r[24]);
        p.ctrl.wb_sel = wb_sel_t'(r[26:25]);
        case (r[29:27] % 6)
            0: p.ctrl.cmpop = beq;
            1: p.ctrl.cmpop = bne;
            2: p.ctrl.cmpop = blt;
            3: p.ctrl.cmpop = bge;
            4: p.ctrl.cmpop = bltu;
            default: p.ctrl.cmpop = bgeu;
        endcase
        p.inst.i_imm = $random(seed);
        p.inst.u_imm = {$random(seed)} & 32'hffff_f000;
        p.inst.b_imm = $random(seed);
        p.inst.s_imm = $random(seed);
        p.inst.j_imm = $random(seed);
        p.data.pc = {$random(seed)} & 32'hffff_fffc;
        return p;
    endfunction

    // Retires the previous model result and issues p in one cycle
    task automatic issue(input rv32i_packet_t p);
        @(posedge clk);
        exp_q.push_back(model_wb);
        if (exp_q.size() > 2) exp_wb <= exp_q.pop_front();
        hist2 = hist1;
        hist1 = arch;
        if (model_wb.load_regfile && model_wb.rd != '0) arch[model_wb.rd] = model_wb.wb_data;
        p.data.rs1_out = hist2[p.inst.rs1];
        p.data.rs2_out = hist2[p.inst.rs2];
        p.data.alu_out = '0;
        p.data.br_en = 1'b0;
        if (p.valid) issue_count++;
        id_in <= p;
        model_pkt <= p;
        model_a <= arch[p.inst.rs1];
        model_b <= arch[p.inst.rs2];
    endtask

    task automatic bubble();
        issue('0);
    endtask

    initial begin
        rv32i_packet_t p;
        arst_n = 1'b0;
        id_in = '0;
        id_in.valid = 1'b1;  // Writes offered while in reset
        id_in.ctrl.load_regfile = 1'b1;
        model_pkt = '0;
        model_a = '0;
        model_b = '0;
        exp_wb = '0;
        for (int i = 0; i < 32; i++) arch[i] = (i == 0) ? '0 : $random(seed);
        hist1 = arch;
        hist2 = arch;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        id_in <= '0;
        for (int op = 0; op < 8; op++) begin  // Each op at distance one
            issue(make_op(alu_ops_t'(op), 5'd5, 5'd1, 5'd2));
            issue(make_op(alu_ops_t'(op), 5'd6, 5'd5, 5'd3));
        end
        issue(make_op(alu_sub, 5'd7, 5'd1, 5'd4));
        bubble();
        issue(make_op(alu_xor, 5'd8, 5'd7, 5'd1));  // Distance two
        issue(make_op(alu_add, 5'd9, 5'd2, 5'd3));
        bubble();
        bubble();
        issue(make_op(alu_or, 5'd10, 5'd9, 5'd1));  // Distance three
        issue(make_op(alu_add, 5'd11, 5'd1, 5'd2));
        issue(make_op(alu_sub, 5'd11, 5'd3, 5'd4));
        issue(make_op(alu_and, 5'd12, 5'd11, 5'd11));  // Youngest writer wins
        issue(make_op(alu_add, 5'd0, 5'd1, 5'd2));
        issue(make_op(alu_add, 5'd13, 5'd0, 5'd0));  // x0 stays zero
        p = make_op(alu_add, 5'd14, 5'd1, 5'd2);
        p.ctrl.load_regfile = 1'b0;
        issue(p);
        issue(make_op(alu_add, 5'd15, 5'd14, 5'd14));
        p = make_op(alu_add, 5'd16, 5'd1, 5'd2);
        p.valid = 1'b0;
        issue(p);
        issue(make_op(alu_add, 5'd17, 5'd16, 5'd16));
        for (int c = 0; c < 8; c++) begin  // Branch target and compare then slt
            p = make_op(alu_add, 5'd18, 5'd1, 5'd2);
            p.ctrl.cmpop = branch_funct3_t'(c);
            p.ctrl.alumux1_sel = alumux1_pc_out;
            p.ctrl.alumux2_sel = alumux2_b_imm;
            p.ctrl.load_regfile = 1'b0;
            if (c != 2 && c != 3) issue(p);
            p.ctrl.alumux1_sel = alumux1_rs1_out;
            p.ctrl.wb_sel = wb_br_en;
            p.ctrl.cmpmux_sel = cmpmux_sel_t'(c[0]);
            p.ctrl.load_regfile = 1'b1;
            if (c != 2 && c != 3) issue(p);
        end
        p = make_op(alu_add, 5'd19, 5'd1, 5'd2);
        p.ctrl.wb_sel = wb_u_imm;  // lui
        issue(p);
        p.ctrl.wb_sel = wb_alu_out;  // auipc
        p.ctrl.alumux1_sel = alumux1_pc_out;
        p.ctrl.alumux2_sel = alumux2_u_imm;
        issue(p);
        p.ctrl.wb_sel = wb_pc_plus4;  // jal
        p.ctrl.alumux2_sel = alumux2_j_imm;
        issue(p);
        repeat (400) issue(rand_pkt());
        t = 0;
        while (wb_count != issue_count && t < 20) begin
            bubble();
            t++;
        end
        if (wb_count != issue_count) begin
            other_errors++;
            $display("Writeback count %0d never matched issue count %0d", wb_count, issue_count);
        end
        bubble();
        bubble();
        bubble();
        $display("Errors: %0d failed checks, %0d other", check_errors, other_errors);
        if (check_errors == 0 && other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+rtl
rtl/rv32i_pkg.sv
rtl/alu.sv
rtl/cmp.sv
rtl/forward_unit.sv
rtl/ex.sv
rtl/pipe_regs.sv
rtl/exec_pipe.sv
test/exec_model.sv
test/tb_exec_pipe.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --assert --timing -j 0
TOP   = tb_exec_pipe
FLIST = list.f
MDIR  = obj_dir
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(MDIR)
	./$(MDIR)/V$(TOP) | tee $(LOG)
	@grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(MDIR) $(LOG)
